/* Makefile */
TOP := tb_husky_ctrl

all: run

build:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module husky_ctrl_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* all.f */
+incdir+tb
design/husky_ctrl_pkg.sv
design/usb_reg_bus.sv
design/target_io_ctrl.sv
design/error_led_ctrl.sv
design/husky_ctrl_top.sv
tb/tb_husky_ctrl.sv

/* design/error_led_ctrl.sv */
`timescale 1ns/1ps

module error_led_ctrl
   import husky_ctrl_pkg::*;
(
   input  logic                 clk_usb_buf,
   input  logic                 rst_n_i,
   input  logic [ADDR_W-1:0]    reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [DATA_W-1:0]    reg_wdata_i,
   input  logic                 reg_write_i,
   input  logic                 fifo_error_i,
   input  logic                 trace_error_i,
   input  logic                 xadc_error_i,
   input  logic                 pll_status_i,
   input  logic                 glitch_active_i,
   input  logic                 led_capture_i,
   input  logic                 led_armed_i,
   output logic [DATA_W-1:0]    read_data_o,
   output logic                 led_adc_o,
   output logic                 led_glitch_o,
   output logic                 led_cap_o,
   output logic                 led_armed_o
);

   logic [2:0]  err_q;
   logic [2:0]  err_set;
   logic [2:0]  err_clr;
   logic        err_any;
   logic [15:0] flash_div_q;
   logic [15:0] flash_cnt_q;
   logic        flash_q;

   always_comb begin
      err_set                = '0;
      err_set[ERR_FIFO_BIT]  = fifo_error_i;
      err_set[ERR_TRACE_BIT] = trace_error_i;
      err_set[ERR_XADC_BIT]  = xadc_error_i;
   end

   assign err_clr = (reg_write_i && reg_address_i == REG_ERRORS) ? reg_wdata_i[2:0] : 3'b000;
   assign err_any = |err_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q       <= '0;
         flash_div_q <= FLASH_DIV_RESET;
      end else begin
         err_q <= (err_q & ~err_clr) | err_set;   // A live input wins over a clear
         if (reg_write_i && reg_address_i == REG_FLASH_DIV) begin
            if (reg_bytecnt_i == BYTECNT_W'(0))
               flash_div_q[7:0] <= reg_wdata_i;
            else if (reg_bytecnt_i == BYTECNT_W'(1))
               flash_div_q[15:8] <= reg_wdata_i;
         end
      end
   end

   // Flash pattern, one toggle per flash_div_q + 1 cycles
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         flash_cnt_q <= '0;
         flash_q     <= 1'b0;
      end else if (!err_any) begin
         flash_cnt_q <= '0;
         flash_q     <= 1'b0;
      end else if (flash_cnt_q >= flash_div_q) begin
         flash_cnt_q <= '0;
         flash_q     <= ~flash_q;
      end else begin
         flash_cnt_q <= flash_cnt_q + 16'd1;
      end
   end

   always_comb begin
      case (reg_address_i)
         REG_ERRORS:    read_data_o = {{(DATA_W-3){1'b0}}, err_q};
         REG_FLASH_DIV: read_data_o = (reg_bytecnt_i == BYTECNT_W'(0)) ?
                                      flash_div_q[7:0] : flash_div_q[15:8];
         default:       read_data_o = '0;
      endcase
   end

   // Red LEDs flash on any error
   assign led_adc_o    = err_any ? flash_q : ~pll_status_i;
   assign led_glitch_o = err_any ? flash_q : glitch_active_i;
   assign led_cap_o    = led_capture_i;
   assign led_armed_o  = led_armed_i;

   a_flash_idle_low: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !err_any |=> !flash_q);

endmodule

/* design/husky_ctrl_pkg.sv */
package husky_ctrl_pkg;

   // Bus widths
   localparam int unsigned ADDR_W      = 8;
   localparam int unsigned DATA_W      = 8;
   localparam int unsigned BYTECNT_W   = 7;
   localparam int unsigned SYNC_STAGES = 2;   // Flops per strobe synchroniser

   // Register map
   localparam logic [ADDR_W-1:0] REG_ERRORS       = 8'h10;  // Sticky, write 1 to clear
   localparam logic [ADDR_W-1:0] REG_FLASH_DIV    = 8'h11;  // 16 bits, little-endian
   localparam logic [ADDR_W-1:0] REG_TARGET_CTRL  = 8'h20;
   localparam logic [ADDR_W-1:0] REG_TARGET_POWER = 8'h21;  // Bit 0 set = power off

   localparam logic [15:0] FLASH_DIV_RESET = 16'd1000;

   // Bit positions inside REG_ERRORS
   localparam int unsigned ERR_FIFO_BIT  = 0;
   localparam int unsigned ERR_TRACE_BIT = 1;
   localparam int unsigned ERR_XADC_BIT  = 2;

   // Target control byte, written whole by the host and used field by field
   typedef union packed {
      logic [DATA_W-1:0] raw;
      struct packed {
         logic reserved;
         logic enable_avrprog;
         logic enable_nrst;
         logic output_nrst;
         logic enable_pdid;
         logic output_pdid;
         logic enable_pdic;
         logic output_pdic;
      } f;
   } target_ctrl_t;

endpackage

/* design/husky_ctrl_top.sv */
`timescale 1ns/1ps

module husky_ctrl_top
   import husky_ctrl_pkg::*;
(
   input  logic              clk_usb_buf,
   input  logic              rst_n_i,
   // Host bus
   input  logic [ADDR_W-1:0] usb_addr_i,
   input  logic [DATA_W-1:0] usb_data_i,
   input  logic              usb_cen_i,
   input  logic              usb_alen_i,
   input  logic              usb_rdn_i,
   input  logic              usb_wrn_i,
   output logic [DATA_W-1:0] usb_data_o,
   output logic              usb_data_oe_o,
   // Target pins
   input  logic              sam_mosi_i,
   input  logic              sam_spck_i,
   input  logic              target_miso_i,
   input  logic              usb_spare0_i,
   output logic              target_poweron_o,
   output logic              target_nrst_o,
   output logic              target_nrst_oe_o,
   output logic              target_pdid_o,
   output logic              target_pdid_oe_o,
   output logic              target_pdic_o,
   output logic              target_pdic_oe_o,
   output logic              target_mosi_o,
   output logic              target_mosi_oe_o,
   output logic              target_sck_o,
   output logic              target_sck_oe_o,
   output logic              sam_miso_o,
   output logic              sam_miso_oe_o,
   // Status and LEDs
   input  logic              fifo_error_i,
   input  logic              trace_error_i,
   input  logic              xadc_error_i,
   input  logic              pll_status_i,
   input  logic              glitch_active_i,
   input  logic              led_capture_i,
   input  logic              led_armed_i,
   output logic              led_adc_o,
   output logic              led_glitch_o,
   output logic              led_cap_o,
   output logic              led_armed_o
);

   logic [ADDR_W-1:0]    reg_address;
   logic [BYTECNT_W-1:0] reg_bytecnt;
   logic [DATA_W-1:0]    reg_wdata;
   logic                 reg_write;
   logic [DATA_W-1:0]    read_data_target;
   logic [DATA_W-1:0]    read_data_status;

   usb_reg_bus u_usb_reg_bus (
      .clk_usb_buf        (clk_usb_buf),
      .rst_n_i            (rst_n_i),
      .usb_addr_i         (usb_addr_i),
      .usb_data_i         (usb_data_i),
      .usb_cen_i          (usb_cen_i),
      .usb_alen_i         (usb_alen_i),
      .usb_rdn_i          (usb_rdn_i),
      .usb_wrn_i          (usb_wrn_i),
      .read_data_target_i (read_data_target),
      .read_data_status_i (read_data_status),
      .reg_address_o      (reg_address),
      .reg_bytecnt_o      (reg_bytecnt),
      .reg_wdata_o        (reg_wdata),
      .reg_write_o        (reg_write),
      .reg_read_o         (),             // No read side effects in these blocks
      .usb_data_o         (usb_data_o),
      .usb_data_oe_o      (usb_data_oe_o)
   );

   target_io_ctrl u_target_io_ctrl (
      .clk_usb_buf      (clk_usb_buf),
      .rst_n_i          (rst_n_i),
      .reg_address_i    (reg_address),
      .reg_wdata_i      (reg_wdata),
      .reg_write_i      (reg_write),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .usb_spare0_i     (usb_spare0_i),
      .read_data_o      (read_data_target),
      .target_poweron_o (target_poweron_o),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_pdid_o    (target_pdid_o),
      .target_pdid_oe_o (target_pdid_oe_o),
      .target_pdic_o    (target_pdic_o),
      .target_pdic_oe_o (target_pdic_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o)
   );

   error_led_ctrl u_error_led_ctrl (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .reg_address_i   (reg_address),
      .reg_bytecnt_i   (reg_bytecnt),
      .reg_wdata_i     (reg_wdata),
      .reg_write_i     (reg_write),
      .fifo_error_i    (fifo_error_i),
      .trace_error_i   (trace_error_i),
      .xadc_error_i    (xadc_error_i),
      .pll_status_i    (pll_status_i),
      .glitch_active_i (glitch_active_i),
      .led_capture_i   (led_capture_i),
      .led_armed_i     (led_armed_i),
      .read_data_o     (read_data_status),
      .led_adc_o       (led_adc_o),
      .led_glitch_o    (led_glitch_o),
      .led_cap_o       (led_cap_o),
      .led_armed_o     (led_armed_o)
   );

endmodule

/* design/target_io_ctrl.sv */
`timescale 1ns/1ps

module target_io_ctrl
   import husky_ctrl_pkg::*;
(
   input  logic              clk_usb_buf,
   input  logic              rst_n_i,
   input  logic [ADDR_W-1:0] reg_address_i,
   input  logic [DATA_W-1:0] reg_wdata_i,
   input  logic              reg_write_i,
   input  logic              sam_mosi_i,
   input  logic              sam_spck_i,
   input  logic              target_miso_i,
   input  logic              usb_spare0_i,
   output logic [DATA_W-1:0] read_data_o,
   output logic              target_poweron_o,
   output logic              target_nrst_o,
   output logic              target_nrst_oe_o,
   output logic              target_pdid_o,
   output logic              target_pdid_oe_o,
   output logic              target_pdic_o,
   output logic              target_pdic_oe_o,
   output logic              target_mosi_o,
   output logic              target_mosi_oe_o,
   output logic              target_sck_o,
   output logic              target_sck_oe_o,
   output logic              sam_miso_o,
   output logic              sam_miso_oe_o
);

   target_ctrl_t ctrl_q;
   logic         power_off_q;
   logic         avrprog;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q.raw  <= '0;
         power_off_q <= 1'b1;   // Board comes up with target unpowered
      end else if (reg_write_i) begin
         if (reg_address_i == REG_TARGET_CTRL)
            ctrl_q.raw <= reg_wdata_i;
         if (reg_address_i == REG_TARGET_POWER)
            power_off_q <= reg_wdata_i[0];
      end
   end

   always_comb begin
      case (reg_address_i)
         REG_TARGET_CTRL:  read_data_o = ctrl_q.raw;
         REG_TARGET_POWER: read_data_o = {{(DATA_W-1){1'b0}}, power_off_q};
         default:          read_data_o = '0;
      endcase
   end

   assign avrprog          = ctrl_q.f.enable_avrprog;
   assign target_poweron_o = ~power_off_q;

   // AVR programming takes nRST over from the manual drive
   assign target_nrst_o    = avrprog ? usb_spare0_i : ctrl_q.f.output_nrst;
   assign target_nrst_oe_o = target_poweron_o & (avrprog | ctrl_q.f.enable_nrst);

   assign target_pdid_o    = ctrl_q.f.output_pdid;
   assign target_pdid_oe_o = target_poweron_o & ctrl_q.f.enable_pdid;
   assign target_pdic_o    = ctrl_q.f.output_pdic;
   assign target_pdic_oe_o = target_poweron_o & ctrl_q.f.enable_pdic;

   // SPI pass-through from the SAM
   assign target_mosi_o    = sam_mosi_i;
   assign target_mosi_oe_o = target_poweron_o & avrprog;
   assign target_sck_o     = sam_spck_i;
   assign target_sck_oe_o  = target_poweron_o & avrprog;

   assign sam_miso_o    = target_miso_i;
   assign sam_miso_oe_o = avrprog;   // SAM side, independent of target power

   // Pins float whenever the target is unpowered
   a_power_off_floats: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      power_off_q |-> !(target_nrst_oe_o || target_pdid_oe_o || target_pdic_oe_o ||
                        target_mosi_oe_o || target_sck_oe_o));

endmodule

/* design/usb_reg_bus.sv */
`timescale 1ns/1ps

module usb_reg_bus
   import husky_ctrl_pkg::*;
(
   input  logic                 clk_usb_buf,
   input  logic                 rst_n_i,
   input  logic [ADDR_W-1:0]    usb_addr_i,
   input  logic [DATA_W-1:0]    usb_data_i,
   input  logic                 usb_cen_i,
   input  logic                 usb_alen_i,
   input  logic                 usb_rdn_i,
   input  logic                 usb_wrn_i,
   input  logic [DATA_W-1:0]    read_data_target_i,
   input  logic [DATA_W-1:0]    read_data_status_i,
   output logic [ADDR_W-1:0]    reg_address_o,
   output logic [BYTECNT_W-1:0] reg_bytecnt_o,
   output logic [DATA_W-1:0]    reg_wdata_o,
   output logic                 reg_write_o,
   output logic                 reg_read_o,
   output logic [DATA_W-1:0]    usb_data_o,
   output logic                 usb_data_oe_o
);

   logic [SYNC_STAGES-1:0] cen_sync;
   logic [SYNC_STAGES-1:0] alen_sync;
   logic [SYNC_STAGES-1:0] rdn_sync;
   logic [SYNC_STAGES-1:0] wrn_sync;
   logic                   rdn_d;   // Last stage delayed, for edges
   logic                   wrn_d;
   logic                   cen_s;
   logic                   alen_s;
   logic                   rdn_s;
   logic                   wrn_s;
   logic                   wr_fall;
   logic                   rd_fall;
   logic                   strobe_rise;
   logic [DATA_W-1:0]      rdata_q;

   // Strobes idle high, so the chains reset to ones
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cen_sync  <= '1;
         alen_sync <= '1;
         rdn_sync  <= '1;
         wrn_sync  <= '1;
         rdn_d     <= 1'b1;
         wrn_d     <= 1'b1;
      end else begin
         cen_sync  <= {cen_sync[SYNC_STAGES-2:0], usb_cen_i};
         alen_sync <= {alen_sync[SYNC_STAGES-2:0], usb_alen_i};
         rdn_sync  <= {rdn_sync[SYNC_STAGES-2:0], usb_rdn_i};
         wrn_sync  <= {wrn_sync[SYNC_STAGES-2:0], usb_wrn_i};
         rdn_d     <= rdn_s;
         wrn_d     <= wrn_s;
      end
   end

   assign cen_s  = cen_sync[SYNC_STAGES-1];
   assign alen_s = alen_sync[SYNC_STAGES-1];
   assign rdn_s  = rdn_sync[SYNC_STAGES-1];
   assign wrn_s  = wrn_sync[SYNC_STAGES-1];

   assign wr_fall     = wrn_d & ~wrn_s & ~cen_s;
   assign rd_fall     = rdn_d & ~rdn_s & ~cen_s;
   assign strobe_rise = (~wrn_d & wrn_s) | (~rdn_d & rdn_s);  // End of one byte

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         reg_write_o   <= 1'b0;
         reg_read_o    <= 1'b0;
         reg_address_o <= '0;
         reg_bytecnt_o <= '0;
      end else begin
         reg_write_o <= wr_fall;
         reg_read_o  <= rd_fall;
         if (!alen_s && !cen_s) begin
            reg_address_o <= usb_addr_i;   // New burst
            reg_bytecnt_o <= '0;
         end else if (strobe_rise) begin
            reg_bytecnt_o <= reg_bytecnt_o + 1'b1;
         end
      end
   end

   // Data path
   always_ff @(posedge clk_usb_buf) begin
      if (wr_fall)
         reg_wdata_o <= usb_data_i;
      rdata_q <= read_data_target_i | read_data_status_i;
      if (reg_read_o)
         usb_data_o <= rdata_q;   // Held for the rest of the strobe
   end

   assign usb_data_oe_o = ~rdn_s & ~cen_s;

   a_no_rd_wr_overlap: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !(reg_write_o && reg_read_o));

endmodule

/* tb/tb_husky_ctrl_ref.svh */
`ifndef TB_HUSKY_CTRL_REF_SVH
`define TB_HUSKY_CTRL_REF_SVH

// Expected target pins as {enable, driven level} pairs, power-on flag on top
// A pin that is not driven is expected at level 0 in its pair
function automatic logic [12:0] expected_pins(input logic [7:0] ctrl,
                                              input logic       power_on,
                                              input logic       sam_mosi,
                                              input logic       sam_sck,
                                              input logic       target_miso,
                                              input logic       spare0);
   logic avr;
   logic nrst_oe;
   logic nrst_lvl;
   logic pdid_oe;
   logic pdic_oe;
   logic spi_oe;
   avr      = ctrl[6];
   nrst_oe  = power_on & (avr | ctrl[5]);
   nrst_lvl = avr ? spare0 : ctrl[4];   // Programmer owns nRST
   pdid_oe  = power_on & ctrl[3];
   pdic_oe  = power_on & ctrl[1];
   spi_oe   = power_on & avr;
   return {power_on,
           nrst_oe, nrst_oe & nrst_lvl,
           pdid_oe, pdid_oe & ctrl[2],
           pdic_oe, pdic_oe & ctrl[0],
           spi_oe, spi_oe & sam_mosi,
           spi_oe, spi_oe & sam_sck,
           avr, avr & target_miso};   // SAM side ignores power
endfunction

// Sticky flags after one cycle of events and a write-1-to-clear mask
function automatic logic [2:0] sticky_flags(input logic [2:0] flags,
                                            input logic [2:0] events,
                                            input logic [2:0] clear_mask);
   return (flags & ~clear_mask) | events;   // Live event beats the clear
endfunction

// Red LED level, flash pattern while any flag is set
function automatic logic expected_led(input logic [2:0] flags,
                                      input logic       flash,
                                      input logic       idle_level);
   return (flags != 3'b000) ? flash : idle_level;
endfunction

`endif

/* tb/tb_husky_ctrl.sv */
`timescale 1ns/1ps

module tb_husky_ctrl
   import husky_ctrl_pkg::*;
();

   localparam int STROBE_LOW  = 8;
   localparam int STROBE_HIGH = 6;
   // About 7500 cycles of tests, limit leaves wide margin
   localparam int TIMEOUT_CYCLES = 40000;

   logic       clk_usb_buf;
   logic       rst_n_i;
   logic [7:0] usb_addr_i;
   logic [7:0] usb_data_i;
   logic       usb_cen_i;
   logic       usb_alen_i;
   logic       usb_rdn_i;
   logic       usb_wrn_i;
   logic [7:0] usb_data_o;
   logic       usb_data_oe_o;
   logic       sam_mosi_i;
   logic       sam_spck_i;
   logic       target_miso_i;
   logic       usb_spare0_i;
   logic       target_poweron_o;
   logic       target_nrst_o;
   logic       target_nrst_oe_o;
   logic       target_pdid_o;
   logic       target_pdid_oe_o;
   logic       target_pdic_o;
   logic       target_pdic_oe_o;
   logic       target_mosi_o;
   logic       target_mosi_oe_o;
   logic       target_sck_o;
   logic       target_sck_oe_o;
   logic       sam_miso_o;
   logic       sam_miso_oe_o;
   logic       fifo_error_i;
   logic       trace_error_i;
   logic       xadc_error_i;
   logic       pll_status_i;
   logic       glitch_active_i;
   logic       led_capture_i;
   logic       led_armed_i;
   logic       led_adc_o;
   logic       led_glitch_o;
   logic       led_cap_o;
   logic       led_armed_o;

   // Model state of the registers
   logic [7:0]  ctrl_model = '0;
   logic        power_on_model = 1'b0;
   logic [2:0]  flags_model = '0;
   logic        pins_valid = 1'b0;   // Pin model in step with the DUT
   logic [12:0] pins_exp;
   logic [12:0] pins_got;
   logic [7:0]  rd_byte;
   logic [7:0]  probe_addr;
   int          errors = 0;
   int          pin_errors = 0;
   int          cycle_count = 0;

   `include "tb_husky_ctrl_ref.svh"

   husky_ctrl_top dut (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #10 clk_usb_buf = ~clk_usb_buf;
   end

   always @(posedge clk_usb_buf) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Something failed");
         $finish;
      end
   end

   // Pin comparison, sampled away from the driving edge
   always @(negedge clk_usb_buf) begin
      if (pins_valid) begin
         pins_exp = expected_pins(ctrl_model, power_on_model, sam_mosi_i, sam_spck_i,
                                  target_miso_i, usb_spare0_i);
         pins_got = {target_poweron_o,
                     target_nrst_oe_o, target_nrst_oe_o & target_nrst_o,
                     target_pdid_oe_o, target_pdid_oe_o & target_pdid_o,
                     target_pdic_oe_o, target_pdic_oe_o & target_pdic_o,
                     target_mosi_oe_o, target_mosi_oe_o & target_mosi_o,
                     target_sck_oe_o, target_sck_oe_o & target_sck_o,
                     sam_miso_oe_o, sam_miso_oe_o & sam_miso_o};
         if (pins_got !== pins_exp) begin
            pin_errors++;
            $display("[ERROR] %0t: target pins %013b, expected %013b (ctrl 0x%02h, power %0b)",
                     $time, pins_got, pins_exp, ctrl_model, power_on_model);
         end
      end
   end

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
      end
   endtask

   task automatic start_burst(input logic [7:0] addr);
      usb_addr_i <= addr;
      usb_cen_i  <= 1'b0;
      usb_alen_i <= 1'b0;
      repeat (STROBE_LOW) @(posedge clk_usb_buf);
      usb_alen_i <= 1'b1;
      repeat (STROBE_HIGH) @(posedge clk_usb_buf);
   endtask

   task automatic end_burst();
      usb_cen_i <= 1'b1;
      repeat (STROBE_HIGH) @(posedge clk_usb_buf);
   endtask

   task automatic write_byte(input logic [7:0] data);
      usb_data_i <= data;
      usb_wrn_i  <= 1'b0;
      repeat (STROBE_LOW) @(posedge clk_usb_buf);
      usb_wrn_i <= 1'b1;
      repeat (STROBE_HIGH) @(posedge clk_usb_buf);
   endtask

   task automatic read_byte(output logic [7:0] data);
      usb_rdn_i <= 1'b0;
      repeat (STROBE_LOW - 1) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      data = usb_data_o;
      if (usb_data_oe_o !== 1'b1) begin
         errors++;
         $display("[ERROR] %0t: usb_data_oe_o low during a read", $time);
      end
      @(posedge clk_usb_buf);
      usb_rdn_i <= 1'b1;
      repeat (STROBE_HIGH) @(posedge clk_usb_buf);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      start_burst(addr);
      write_byte(data);
      end_burst();
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      start_burst(addr);
      read_byte(data);
      end_burst();
   endtask

   // Pin checks pause while the write travels to the pins
   task automatic write_target_reg(input logic [7:0] addr, input logic [7:0] data);
      pins_valid = 1'b0;
      write_reg(addr, data);
      if (addr == REG_TARGET_CTRL)
         ctrl_model = data;
      else
         power_on_model = ~data[0];
      pins_valid = 1'b1;
   endtask

   task automatic toggle_pin_inputs(input int n);
      repeat (n) begin
         sam_mosi_i    <= 1'($urandom);
         sam_spck_i    <= 1'($urandom);
         target_miso_i <= 1'($urandom);
         usb_spare0_i  <= 1'($urandom);
         @(posedge clk_usb_buf);
      end
   endtask

   task automatic run_pin_pass(input int n);
      logic [7:0] ctrl;
      logic [7:0] rd;
      repeat (n) begin
         ctrl = 8'($urandom);
         write_target_reg(REG_TARGET_CTRL, ctrl);
         toggle_pin_inputs(4);
         read_reg(REG_TARGET_CTRL, rd);
         check_byte("target control", rd, ctrl);
      end
   endtask

   task automatic write_errors(input logic [2:0] mask);
      write_reg(REG_ERRORS, {5'b00000, mask});
      flags_model = sticky_flags(flags_model, 3'b000, mask);
   endtask

   task automatic pulse_error(input logic [2:0] ev);
      fifo_error_i  <= ev[ERR_FIFO_BIT];
      trace_error_i <= ev[ERR_TRACE_BIT];
      xadc_error_i  <= ev[ERR_XADC_BIT];
      @(posedge clk_usb_buf);
      fifo_error_i  <= 1'b0;
      trace_error_i <= 1'b0;
      xadc_error_i  <= 1'b0;
      @(posedge clk_usb_buf);
      flags_model = sticky_flags(flags_model, ev, 3'b000);
   endtask

   // Flash starts low, so the first change is a rise
   task automatic check_flash(input int toggles, input int period);
      int   gap;
      int   seen;
      logic last;
      gap  = 0;
      seen = 0;
      last = 1'b0;
      while (seen < toggles) begin
         @(negedge clk_usb_buf);
         gap++;
         if (led_glitch_o !== led_adc_o) begin
            errors++;
            $display("[ERROR] %0t: led_glitch_o %0b differs from led_adc_o %0b",
                     $time, led_glitch_o, led_adc_o);
         end
         if (led_adc_o !== last) begin
            if (seen > 0 && gap != period) begin
               errors++;
               $display("[ERROR] %0t: LED flash toggled after %0d cycles, expected %0d",
                        $time, gap, period);
            end
            seen++;
            gap  = 0;
            last = led_adc_o;
         end
      end
      @(posedge clk_usb_buf);
   endtask

   task automatic check_idle_leds(input int n);
      repeat (n) begin
         pll_status_i    <= 1'($urandom);
         glitch_active_i <= 1'($urandom);
         led_capture_i   <= 1'($urandom);
         led_armed_i     <= 1'($urandom);
         @(negedge clk_usb_buf);
         if (led_adc_o !== expected_led(flags_model, 1'b0, ~pll_status_i) ||
             led_glitch_o !== expected_led(flags_model, 1'b0, glitch_active_i)) begin
            errors++;
            $display("[ERROR] %0t: red LEDs %0b%0b with pll %0b glitch %0b", $time,
                     led_adc_o, led_glitch_o, pll_status_i, glitch_active_i);
         end
         if (led_cap_o !== led_capture_i || led_armed_o !== led_armed_i) begin
            errors++;
            $display("[ERROR] %0t: capture or armed LED does not follow its input", $time);
         end
         @(posedge clk_usb_buf);
      end
   endtask

   initial begin
      void'($urandom(85457));
      rst_n_i         = 1'b0;
      usb_addr_i      = '0;
      usb_data_i      = '0;
      usb_cen_i       = 1'b1;
      usb_alen_i      = 1'b1;
      usb_rdn_i       = 1'b1;
      usb_wrn_i       = 1'b1;
      sam_mosi_i      = 1'b0;
      sam_spck_i      = 1'b0;
      target_miso_i   = 1'b0;
      usb_spare0_i    = 1'b0;
      fifo_error_i    = 1'b0;
      trace_error_i   = 1'b0;
      xadc_error_i    = 1'b0;
      pll_status_i    = 1'b1;
      glitch_active_i = 1'b0;
      led_capture_i   = 1'b0;
      led_armed_i     = 1'b0;
      repeat (3) @(posedge clk_usb_buf);
      rst_n_i <= 1'b1;
      @(posedge clk_usb_buf);

      // Reset state
      pins_valid = 1'b1;
      @(negedge clk_usb_buf);
      if (usb_data_oe_o !== 1'b0) begin
         errors++;
         $display("[ERROR] %0t: usb_data_oe_o high after reset", $time);
      end
      @(posedge clk_usb_buf);
      read_reg(REG_ERRORS, rd_byte);
      check_byte("error flags after reset", rd_byte, 8'h00);
      start_burst(REG_FLASH_DIV);
      read_byte(rd_byte);
      check_byte("flash divider low byte", rd_byte, 8'hE8);   // 1000
      read_byte(rd_byte);
      check_byte("flash divider high byte", rd_byte, 8'h03);
      end_burst();

      // Target pins, powered then unpowered
      write_target_reg(REG_TARGET_POWER, 8'h00);
      run_pin_pass(40);
      write_target_reg(REG_TARGET_POWER, 8'h01);
      run_pin_pass(40);

      // AVR programming pass-through
      write_target_reg(REG_TARGET_POWER, 8'h00);
      write_target_reg(REG_TARGET_CTRL, {2'b01, 6'($urandom)});
      toggle_pin_inputs(64);

      // Sticky error flags
      repeat (8) begin
         write_errors(3'b111);
         repeat ($urandom_range(1, 3)) pulse_error(3'b001 << $urandom_range(0, 2));
         read_reg(REG_ERRORS, rd_byte);
         check_byte("sticky error flags", rd_byte, {5'b00000, flags_model});
         write_errors(3'($urandom));
         read_reg(REG_ERRORS, rd_byte);
         check_byte("error flags after clear", rd_byte, {5'b00000, flags_model});
      end

      // LED override with a short divider
      write_errors(3'b111);
      start_burst(REG_FLASH_DIV);
      write_byte(8'd5);
      write_byte(8'd0);
      end_burst();
      pulse_error(3'b100);
      check_flash(6, 6);
      write_errors(3'b111);
      check_idle_leds(16);

      // Unused addresses read as zero
      repeat (6) begin
         do begin
            probe_addr = 8'($urandom);
         end while (probe_addr == REG_ERRORS || probe_addr == REG_FLASH_DIV ||
                    probe_addr == REG_TARGET_CTRL || probe_addr == REG_TARGET_POWER);
         read_reg(probe_addr, rd_byte);
         check_byte("unused address", rd_byte, 8'h00);
      end

      $display("Checks done: %0d register and LED errors, %0d pin errors", errors, pin_errors);
      if (errors == 0 && pin_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
